//--- testbench/router_stat_trace.txt
# E flit_wr_i pck_wr_i flit_wr_o pck_wr_o bypassed (hex, bit per port) byp_num (hex, 2b/port) repeat gap
# I cycles | W | C | R port field bin expected | B port field bin max | O overflow
# fields: 0 flit_in 1 pck_in 2 flit_out 3 pck_out 4 flit_buf 5 flit_byp 6 hist
# per-port wr counts, ports kept apart
E 1 1 0 0 0 00 3 6
I 4
E 2 0 2 0 0 00 5 6
I 4
E 4 0 0 4 0 00 2 6
I 4
E 8 8 8 8 0 00 1 6
E 0 0 3 0 0 00 4 6
W
R 0 0 0 3
R 0 1 0 3
R 0 2 0 4
R 0 3 0 0
R 1 0 0 5
R 1 1 0 0
R 1 2 0 9
R 1 3 0 0
R 2 0 0 2
R 2 1 0 0
R 2 2 0 0
R 2 3 0 2
R 3 0 0 1
R 3 1 0 1
R 3 2 0 1
R 3 3 0 1
# buffered against bypassed flits, histogram bins
E 2 0 0 0 2 00 2 6
E 2 0 0 0 0 04 3 6
E 2 0 0 0 0 0c 1 6
E 8 0 0 0 0 80 2 6
E 8 0 0 0 8 c0 1 6
W
R 1 0 0 11
R 1 4 0 9
R 1 5 0 2
R 1 6 0 5
R 1 6 1 3
R 1 6 2 0
R 1 6 3 1
R 3 0 0 4
R 3 4 0 3
R 3 5 0 1
R 3 6 0 1
R 3 6 1 0
R 3 6 2 2
R 3 6 3 0
# saturation at 63 on port 2
E 4 0 0 0 0 00 70 6
W
R 2 0 0 63
R 2 4 0 63
R 2 6 0 63
R 2 3 0 2
R 0 0 0 3
R 1 0 0 11
R 3 0 0 4
# back-to-back burst overruns the FIFO
W
C
E f f f f 0 00 16 0
O 1
W
B 0 0 0 16
B 1 1 0 16
B 2 4 0 16
B 3 6 0 16
R 3 6 1 0
R 0 5 0 0
# clear, then count again from zero
W
C
O 0
E 1 0 0 1 0 00 2 6
W
R 0 0 0 2
R 0 3 0 2
R 0 4 0 2
R 1 0 0 0

//--- project.f
src/noc_stat_pkg.sv
src/port_event_sampler.sv
src/event_fifo.sv
src/stat_counter_bank.sv
src/router_stat_top.sv
testbench/router_stat_tb.sv

//--- testbench/router_stat_tb.sv
`timescale 1ns/1ns

module router_stat_tb;
    import noc_stat_pkg::*;

    localparam int NP         = 4;
    localparam int BYP_MAX    = 3;
    localparam int BYP_W      = 2;
    localparam int PW         = $clog2(NP);
    localparam int CNT_W      = 6;
    localparam int FIFO_DEPTH = 8;
    localparam int CLK_NS     = 20;
    localparam int MAX_REC    = 256;

    typedef enum logic [2:0] {
        OP_EVT, OP_IDLE, OP_WAIT, OP_CLEAR, OP_READ, OP_BOUND, OP_OVF
    } trace_op_e;

    logic               clk;
    logic               reset;
    logic               clear;
    logic [NP-1:0]      flit_wr_i;
    logic [NP-1:0]      pck_wr_i;
    logic [NP-1:0]      flit_wr_o;
    logic [NP-1:0]      pck_wr_o;
    logic [NP-1:0]      flit_in_bypassed;
    logic [NP*BYP_W-1:0] bypassed_num;
    logic               rd_en;
    logic [PW-1:0]      rd_port;
    stat_field_e        rd_field;
    logic [BYP_W-1:0]   rd_bin;
    logic [CNT_W-1:0]   rd_data;
    logic               rd_valid;
    logic               overflow;
    logic               busy;

    trace_op_e rec_op   [MAX_REC];
    int        rec_line [MAX_REC];
    int        rec_arg  [MAX_REC][8];
    int        rec_cnt;
    longint    rep_sum;
    longint    limit_ns;
    bit        limit_set = 1'b0;
    int        n_checks;

    router_stat_top #(
        .NP         (NP),
        .BYP_MAX    (BYP_MAX),
        .CNT_W      (CNT_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_router_stat_top (
        .clk              (clk),
        .reset            (reset),
        .clear            (clear),
        .flit_wr_i        (flit_wr_i),
        .pck_wr_i         (pck_wr_i),
        .flit_wr_o        (flit_wr_o),
        .pck_wr_o         (pck_wr_o),
        .flit_in_bypassed (flit_in_bypassed),
        .bypassed_num     (bypassed_num),
        .rd_en            (rd_en),
        .rd_port          (rd_port),
        .rd_field         (rd_field),
        .rd_bin           (rd_bin),
        .rd_data          (rd_data),
        .rd_valid         (rd_valid),
        .overflow         (overflow),
        .busy             (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic load_trace();
        int               fd;
        int               line_no;
        int               n;
        int               want;
        logic [8*160-1:0] line_buf;
        byte              op_ch;
        trace_op_e        op;
        int               a0, a1, a2, a3, a4, a5, a6, a7;
        fd      = $fopen("testbench/router_stat_trace.txt", "r");
        line_no = 0;
        rec_cnt = 0;
        rep_sum = 0;
        if (fd == 0) report_fail("cannot open testbench/router_stat_trace.txt");
        while (!$feof(fd)) begin
            line_buf = '0;
            n = $fgets(line_buf, fd);
            if (n == 0) break;
            line_no++;
            {a0, a1, a2, a3, a4, a5, a6, a7} = '0;
            n = $sscanf(line_buf, " %c", op_ch);
            if (n != 1 || op_ch == "#") continue;  // blank or comment
            case (op_ch)
                "E": begin
                    op   = OP_EVT;
                    want = 9;
                    n = $sscanf(line_buf, " %c %h %h %h %h %h %h %d %d", op_ch,
                                a0, a1, a2, a3, a4, a5, a6, a7);
                    rep_sum += a6;
                end
                "I": begin
                    op   = OP_IDLE;
                    want = 2;
                    n = $sscanf(line_buf, " %c %d", op_ch, a0);
                    rep_sum += a0;
                end
                "W", "C": begin
                    op   = (op_ch == "W") ? OP_WAIT : OP_CLEAR;
                    want = 1;
                end
                "R", "B": begin
                    op   = (op_ch == "R") ? OP_READ : OP_BOUND;
                    want = 5;
                    n = $sscanf(line_buf, " %c %d %d %d %d", op_ch, a0, a1, a2, a3);
                end
                "O": begin
                    op   = OP_OVF;
                    want = 2;
                    n = $sscanf(line_buf, " %c %d", op_ch, a0);
                end
                default: begin
                    op   = OP_WAIT;
                    want = 0;
                    report_fail($sformatf("unknown opcode on trace line %0d", line_no));
                end
            endcase
            if (n != want) report_fail($sformatf("malformed trace line %0d", line_no));
            if (rec_cnt >= MAX_REC) report_fail("trace holds too many lines");
            rec_op[rec_cnt]   = op;
            rec_line[rec_cnt] = line_no;
            rec_arg[rec_cnt][0] = a0;
            rec_arg[rec_cnt][1] = a1;
            rec_arg[rec_cnt][2] = a2;
            rec_arg[rec_cnt][3] = a3;
            rec_arg[rec_cnt][4] = a4;
            rec_arg[rec_cnt][5] = a5;
            rec_arg[rec_cnt][6] = a6;
            rec_arg[rec_cnt][7] = a7;
            rec_cnt++;
        end
        $fclose(fd);
    endtask

    task automatic zero_strobes();
        flit_wr_i        = '0;
        pck_wr_i         = '0;
        flit_wr_o        = '0;
        pck_wr_o         = '0;
        flit_in_bypassed = '0;
        bypassed_num     = '0;
    endtask

    // one strobe cycle per repeat followed by gap idle cycles
    task automatic run_events(input int r);
        for (int k = 0; k < rec_arg[r][6]; k++) begin
            @(negedge clk);
            flit_wr_i        = NP'(rec_arg[r][0]);
            pck_wr_i         = NP'(rec_arg[r][1]);
            flit_wr_o        = NP'(rec_arg[r][2]);
            pck_wr_o         = NP'(rec_arg[r][3]);
            flit_in_bypassed = NP'(rec_arg[r][4]);
            bypassed_num     = (NP*BYP_W)'(rec_arg[r][5]);
            repeat (rec_arg[r][7]) begin
                @(negedge clk);
                zero_strobes();
            end
        end
        @(negedge clk);
        zero_strobes();
    endtask

    task automatic wait_idle();
        @(negedge clk);  // lets the last sampled word reach the FIFO
        while (busy) @(negedge clk);
    endtask

    task automatic read_counter(input int line_no, input int port, input int field,
                                input int bin, output int data);
        @(negedge clk);
        rd_en    = 1'b1;
        rd_port  = PW'(port);
        rd_field = stat_field_e'(field);
        rd_bin   = BYP_W'(bin);
        @(negedge clk);
        rd_en = 1'b0;
        assert (rd_valid === 1'b1) else
            report_fail($sformatf("read on line %0d returned no rd_valid", line_no));
        data = int'(rd_data);
    endtask

    task automatic check_value(input string name, input int exp, input int got);
        n_checks++;
        assert (got == exp) else
            report_fail($sformatf("Error %s: expected %0d, actual %0d", name, exp, got));
    endtask

    // every field and bin of every port and the overflow flag
    task automatic check_all_zero(input int line_no);
        int got;
        for (int p = 0; p < NP; p++) begin
            for (int f = 0; f <= int'(FLD_HIST); f++) begin
                for (int b = 0; b <= ((f == int'(FLD_HIST)) ? BYP_MAX : 0); b++) begin
                    read_counter(line_no, p, f, b, got);
                    check_value($sformatf("line %0d port %0d field %0d bin %0d",
                                          line_no, p, f, b), 0, got);
                end
            end
        end
        check_value($sformatf("line %0d overflow", line_no), 0, int'(overflow));
    endtask

    initial begin
        wait (limit_set);
        #(limit_ns);
        $display("timeout: the trace did not finish within %0d ns", limit_ns);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int got;
        reset    = 1'b1;
        clear    = 1'b0;
        rd_en    = 1'b0;
        rd_port  = '0;
        rd_field = FLD_FLIT_IN;
        rd_bin   = '0;
        zero_strobes();
        n_checks = 0;
        load_trace();
        limit_ns  = (rep_sum + rec_cnt) * (NP + 4) * CLK_NS * 2;
        limit_set = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("reset busy", 0, int'(busy));
        check_value("reset overflow", 0, int'(overflow));
        check_value("reset rd_valid", 0, int'(rd_valid));
        for (int r = 0; r < rec_cnt; r++) begin
            case (rec_op[r])
                OP_EVT:  run_events(r);
                OP_IDLE: repeat (rec_arg[r][0]) @(negedge clk);
                OP_WAIT: wait_idle();
                OP_CLEAR: begin
                    @(negedge clk);
                    clear = 1'b1;
                    @(negedge clk);
                    clear = 1'b0;
                    check_all_zero(rec_line[r]);
                end
                OP_READ: begin
                    read_counter(rec_line[r], rec_arg[r][0], rec_arg[r][1], rec_arg[r][2], got);
                    check_value($sformatf("line %0d", rec_line[r]), rec_arg[r][3], got);
                end
                OP_BOUND: begin
                    read_counter(rec_line[r], rec_arg[r][0], rec_arg[r][1], rec_arg[r][2], got);
                    n_checks++;
                    assert (got <= rec_arg[r][3]) else report_fail($sformatf(
                        "Error line %0d: expected at most %0d, actual %0d",
                        rec_line[r], rec_arg[r][3], got));
                end
                OP_OVF: begin
                    @(negedge clk);
                    check_value($sformatf("line %0d", rec_line[r]), rec_arg[r][0],
                                int'(overflow));
                end
                default: report_fail("bad record in the loaded trace");
            endcase
        end
        @(negedge clk);
        if (n_checks > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_fail("no checks ran, the trace holds no reads");
        end
    end

endmodule

//--- src/router_stat_top.sv
`timescale 1ns/1ns

module router_stat_top #(
    parameter int  NP         = noc_stat_pkg::DEF_NP,
    parameter int  BYP_MAX    = noc_stat_pkg::DEF_BYP_MAX,
    parameter int  CNT_W      = noc_stat_pkg::DEF_CNT_W,
    parameter int  FIFO_DEPTH = noc_stat_pkg::DEF_FIFO_DEPTH,
    localparam int BYP_W      = (BYP_MAX > 0) ? $clog2(BYP_MAX + 1) : 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clear,
    input  logic [NP-1:0]              flit_wr_i,
    input  logic [NP-1:0]              pck_wr_i,
    input  logic [NP-1:0]              flit_wr_o,
    input  logic [NP-1:0]              pck_wr_o,
    input  logic [NP-1:0]              flit_in_bypassed,
    input  logic [NP*BYP_W-1:0]        bypassed_num,
    input  logic                       rd_en,
    input  logic [$clog2(NP)-1:0]      rd_port,
    input  noc_stat_pkg::stat_field_e  rd_field,
    input  logic [BYP_W-1:0]           rd_bin,
    output logic [CNT_W-1:0]           rd_data,
    output logic                       rd_valid,
    output logic                       overflow,
    output logic                       busy
);
    import noc_stat_pkg::*;

    localparam int WORD_W = NP * (EVT_BITS + BYP_W);  // event word width

    logic              push;
    logic [WORD_W-1:0] push_word;
    logic              full;
    logic              pop;
    logic [WORD_W-1:0] pop_word;
    logic              empty;

    port_event_sampler #(
        .NP    (NP),
        .BYP_W (BYP_W)
    ) u_port_event_sampler (
        .clk              (clk),
        .reset            (reset),
        .clear            (clear),
        .flit_wr_i        (flit_wr_i),
        .pck_wr_i         (pck_wr_i),
        .flit_wr_o        (flit_wr_o),
        .pck_wr_o         (pck_wr_o),
        .flit_in_bypassed (flit_in_bypassed),
        .bypassed_num     (bypassed_num),
        .full             (full),
        .push             (push),
        .push_word        (push_word),
        .overflow         (overflow)
    );

    event_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (FIFO_DEPTH)
    ) u_event_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .pop_word  (pop_word),
        .full      (full),
        .empty     (empty)
    );

    stat_counter_bank #(
        .NP      (NP),
        .BYP_MAX (BYP_MAX),
        .BYP_W   (BYP_W),
        .CNT_W   (CNT_W)
    ) u_stat_counter_bank (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .empty    (empty),
        .pop      (pop),
        .pop_word (pop_word),
        .rd_en    (rd_en),
        .rd_port  (rd_port),
        .rd_field (rd_field),
        .rd_bin   (rd_bin),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .busy     (busy)
    );

endmodule

//--- src/stat_counter_bank.sv
`timescale 1ns/1ns

module stat_counter_bank #(
    parameter int NP      = 4,
    parameter int BYP_MAX = 3,
    parameter int BYP_W   = 2,
    parameter int CNT_W   = 16
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          clear,
    input  logic                                          empty,
    output logic                                          pop,
    input  logic [NP*(noc_stat_pkg::EVT_BITS+BYP_W)-1:0]  pop_word,
    input  logic                                          rd_en,
    input  logic [$clog2(NP)-1:0]                         rd_port,
    input  noc_stat_pkg::stat_field_e                     rd_field,
    input  logic [BYP_W-1:0]                              rd_bin,
    output logic [CNT_W-1:0]                              rd_data,
    output logic                                          rd_valid,
    output logic                                          busy
);
    import noc_stat_pkg::*;

    localparam int SW = EVT_BITS + BYP_W;
    localparam int PW = $clog2(NP);
    localparam int NB = BYP_MAX + 1;  // histogram bins

    bank_state_e      state;
    logic             loading;
    logic [PW-1:0]    port_idx;
    logic [NP*SW-1:0] word_q;
    logic             clear_go;

    logic [CNT_W-1:0] flit_in_cnt  [NP];
    logic [CNT_W-1:0] pck_in_cnt   [NP];
    logic [CNT_W-1:0] flit_out_cnt [NP];
    logic [CNT_W-1:0] pck_out_cnt  [NP];
    logic [CNT_W-1:0] flit_buf_cnt [NP];
    logic [CNT_W-1:0] flit_byp_cnt [NP];
    logic [CNT_W-1:0] hist_cnt     [NP][NB];

    logic [SW-1:0]    slice;
    logic             ev_flit_in;
    logic             ev_pck_in;
    logic             ev_flit_out;
    logic             ev_pck_out;
    logic             ev_byp;
    logic [BYP_W-1:0] byp_num;
    logic             hist_hit;

    logic [CNT_W-1:0] flit_in_inc;
    logic [CNT_W-1:0] pck_in_inc;
    logic [CNT_W-1:0] flit_out_inc;
    logic [CNT_W-1:0] pck_out_inc;
    logic [CNT_W-1:0] buf_inc;
    logic [CNT_W-1:0] byp_inc;
    logic [CNT_W-1:0] hist_inc;

    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
        return (&v) ? v : v + 1'b1;  // holds at all ones
    endfunction

    assign clear_go = (state == ST_IDLE) && !loading && clear;
    assign pop      = (state == ST_IDLE) && !loading && !clear && !empty;
    assign busy     = !empty || loading || (state != ST_IDLE);

    // idle with loading set is the cycle where pop_word becomes valid
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            loading  <= 1'b0;
            port_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (clear_go) begin
                        state <= ST_CLEAR;
                    end else if (loading) begin
                        loading  <= 1'b0;
                        port_idx <= '0;
                        state    <= ST_WALK;
                    end else if (pop) begin
                        loading <= 1'b1;
                    end
                end
                ST_WALK: begin
                    if (port_idx == PW'(NP - 1)) state <= ST_IDLE;
                    port_idx <= port_idx + 1'b1;
                end
                ST_CLEAR: state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && loading) begin
            word_q <= pop_word;
        end
    end

    // current port slice
    assign slice       = word_q[port_idx*SW +: SW];
    assign ev_flit_in  = slice[0];
    assign ev_pck_in   = slice[1];
    assign ev_flit_out = slice[2];
    assign ev_pck_out  = slice[3];
    assign ev_byp      = slice[4];
    assign byp_num     = slice[EVT_BITS +: BYP_W];
    assign hist_hit    = int'(byp_num) <= BYP_MAX;

    // one set of incrementers shared by all ports
    always_comb begin
        flit_in_inc  = sat_inc(flit_in_cnt[port_idx]);
        pck_in_inc   = sat_inc(pck_in_cnt[port_idx]);
        flit_out_inc = sat_inc(flit_out_cnt[port_idx]);
        pck_out_inc  = sat_inc(pck_out_cnt[port_idx]);
        buf_inc      = sat_inc(flit_buf_cnt[port_idx]);
        byp_inc      = sat_inc(flit_byp_cnt[port_idx]);
        hist_inc     = sat_inc(hist_cnt[port_idx][byp_num]);
    end

    always_ff @(posedge clk) begin
        if (reset || clear_go) begin
            for (int p = 0; p < NP; p++) begin
                flit_in_cnt[p]  <= '0;
                pck_in_cnt[p]   <= '0;
                flit_out_cnt[p] <= '0;
                pck_out_cnt[p]  <= '0;
                flit_buf_cnt[p] <= '0;
                flit_byp_cnt[p] <= '0;
                for (int b = 0; b < NB; b++) begin
                    hist_cnt[p][b] <= '0;
                end
            end
        end else if (state == ST_WALK) begin
            if (ev_flit_in)  flit_in_cnt[port_idx]  <= flit_in_inc;
            if (ev_pck_in)   pck_in_cnt[port_idx]   <= pck_in_inc;
            if (ev_flit_out) flit_out_cnt[port_idx] <= flit_out_inc;
            if (ev_pck_out)  pck_out_cnt[port_idx]  <= pck_out_inc;
            if (ev_byp) begin
                flit_byp_cnt[port_idx] <= byp_inc;
            end else if (ev_flit_in) begin
                flit_buf_cnt[port_idx] <= buf_inc;  // buffered flit
                if (hist_hit) hist_cnt[port_idx][byp_num] <= hist_inc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (rd_field)
                FLD_FLIT_IN:  rd_data <= flit_in_cnt[rd_port];
                FLD_PCK_IN:   rd_data <= pck_in_cnt[rd_port];
                FLD_FLIT_OUT: rd_data <= flit_out_cnt[rd_port];
                FLD_PCK_OUT:  rd_data <= pck_out_cnt[rd_port];
                FLD_FLIT_BUF: rd_data <= flit_buf_cnt[rd_port];
                FLD_FLIT_BYP: rd_data <= flit_byp_cnt[rd_port];
                FLD_HIST:     rd_data <= (int'(rd_bin) <= BYP_MAX) ?
                                         hist_cnt[rd_port][rd_bin] : '0;
                default:      rd_data <= '0;  // unused encoding
            endcase
        end
    end

endmodule

//--- src/event_fifo.sv
`timescale 1ns/1ns

module event_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_word,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_word,
    output logic             full,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is 2**AW
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
        if (do_pop) begin
            pop_word <= mem[rd_ptr];  // valid the cycle after pop
        end
    end

endmodule

//--- src/port_event_sampler.sv
`timescale 1ns/1ns

module port_event_sampler #(
    parameter int NP    = 4,
    parameter int BYP_W = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          clear,
    input  logic [NP-1:0]                                 flit_wr_i,
    input  logic [NP-1:0]                                 pck_wr_i,
    input  logic [NP-1:0]                                 flit_wr_o,
    input  logic [NP-1:0]                                 pck_wr_o,
    input  logic [NP-1:0]                                 flit_in_bypassed,
    input  logic [NP*BYP_W-1:0]                           bypassed_num,
    input  logic                                          full,
    output logic                                          push,
    output logic [NP*(noc_stat_pkg::EVT_BITS+BYP_W)-1:0]  push_word,
    output logic                                          overflow
);
    import noc_stat_pkg::*;

    localparam int SW = EVT_BITS + BYP_W;  // bits per port slice

    logic [NP*SW-1:0] word_d;
    logic             any_evt;
    logic             word_vld;

    // slice layout from bit 0 is fi pi fo po byp and then the byp count
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            word_d[p*SW +: SW] = {bypassed_num[p*BYP_W +: BYP_W], flit_in_bypassed[p],
                                  pck_wr_o[p], flit_wr_o[p], pck_wr_i[p], flit_wr_i[p]};
        end
    end

    assign any_evt = |{flit_wr_i, pck_wr_i, flit_wr_o, pck_wr_o, flit_in_bypassed};

    always_ff @(posedge clk) begin
        if (reset) begin
            word_vld <= 1'b0;
        end else begin
            word_vld <= any_evt;  // empty cycles never stored
        end
    end

    always_ff @(posedge clk) begin
        if (any_evt) begin
            push_word <= word_d;
        end
    end

    assign push = word_vld && !full;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            overflow <= 1'b0;
        end else if (word_vld && full) begin
            overflow <= 1'b1;  // sticky until clear
        end
    end

endmodule

//--- src/noc_stat_pkg.sv
package noc_stat_pkg;

    // counter kind returned by a read
    typedef enum logic [2:0] {
        FLD_FLIT_IN  = 3'd0,
        FLD_PCK_IN   = 3'd1,
        FLD_FLIT_OUT = 3'd2,
        FLD_PCK_OUT  = 3'd3,
        FLD_FLIT_BUF = 3'd4,
        FLD_FLIT_BYP = 3'd5,
        FLD_HIST     = 3'd6  // bypass histogram bin chosen by rd_bin
    } stat_field_e;

    // consumer side of the counter bank
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,  // waiting for a word or a clear
        ST_WALK  = 2'd1,  // one port slice per cycle
        ST_CLEAR = 2'd2
    } bank_state_e;

    // strobe bits per port slice below the bypass count
    localparam int EVT_BITS = 5;

    localparam int DEF_NP         = 4;
    localparam int DEF_BYP_MAX    = 3;
    localparam int DEF_CNT_W      = 16;
    localparam int DEF_FIFO_DEPTH = 8;  // power of two

endpackage
